/* all.f */
source/core_pkg.sv
source/expipe_pkg.sv
source/modn_counter.sv
source/instr_decoder.sv
source/issue_queue_fifo.sv
source/issue_dispatch.sv
source/issue_stage.sv
tests/issue_stage_assert.sv
tests/tb_issue_stage.sv

/* run.sh */
#!/bin/sh
# Build the issue stage testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_issue_stage -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_issue_stage > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ] || ! grep -q "TESTS PASSED" "$LOG"; then
    echo "Simulation ended without passing"
    exit 1
fi
echo "Simulation passed"
exit 0

/* tests/tb_issue_stage.sv */
// Testbench for the issue stage; table rows are pushed in order and checked at the unit handshakes
`timescale 1ns/1ps

module tb_issue_stage
    import core_pkg::*;
    import expipe_pkg::*;
();

    localparam int IQ_DEPTH    = 4;
    localparam int NUM_ROWS    = 11;
    localparam int TIMEOUT_CYC = 20 * NUM_ROWS + 200;

    // Unit codes of the reference model
    localparam logic [1:0] U_ALU = 2'd0;
    localparam logic [1:0] U_BR  = 2'd1;
    localparam logic [1:0] U_LSU = 2'd2;

    // Ready policy for the three units
    localparam int HOLD_RAND = 0;
    localparam int HOLD_LOW  = 1;
    localparam int HOLD_HIGH = 2;

    typedef struct packed {
        logic [31:0] instr;
        logic [1:0]  unit;
        logic        except;
        logic [7:0]  stall;
    } stim_row_t;

    // One expected operation at a unit
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic [1:0]  unit;
        logic        except;
    } exp_op_t;

    // Instruction word, expected unit, expected exception, cycles of forced unit stall
    localparam stim_row_t STIM [NUM_ROWS] = '{
        '{32'h003100b3, U_ALU, 1'b0, 8'd0},  // add
        '{32'h00500093, U_ALU, 1'b0, 8'd0},  // addi
        '{32'h00012283, U_LSU, 1'b0, 8'd6},  // lw
        '{32'h00208463, U_BR,  1'b0, 8'd0},  // beq
        '{32'h12345137, U_ALU, 1'b0, 8'd0},  // lui
        '{32'h00512223, U_LSU, 1'b0, 8'd0},  // sw
        '{32'h010000ef, U_BR,  1'b0, 8'd8},  // jal
        '{32'hffffffff, U_ALU, 1'b1, 8'd0},  // unknown opcode
        '{32'h00001197, U_ALU, 1'b0, 8'd0},  // auipc
        '{32'h00008067, U_BR,  1'b0, 8'd0},  // jalr
        '{32'h00004501, U_ALU, 1'b1, 8'd3}   // compressed encoding
    };

    logic      clk_i;
    logic      rst_n_i;
    logic      flush_i;
    logic      fetch_valid_i;
    fetch_t    fetch_i;
    logic      fetch_ready_o;
    logic      alu_valid_o;
    logic      alu_ready_i;
    logic      br_valid_o;
    logic      br_ready_i;
    logic      lsu_valid_o;
    logic      lsu_ready_i;
    issue_op_t op_o;

    logic [31:0] rng_state;
    int          hold_mode;
    int          stall_left;
    int          cycle_cnt;
    // Operations accepted at the fetch side and not yet seen at a unit
    exp_op_t     model [$];

    issue_stage #(
        .IQ_DEPTH (IQ_DEPTH)
    ) i_issue_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_i       (fetch_i),
        .fetch_ready_o (fetch_ready_o),
        .alu_valid_o   (alu_valid_o),
        .alu_ready_i   (alu_ready_i),
        .br_valid_o    (br_valid_o),
        .br_ready_i    (br_ready_i),
        .lsu_valid_o   (lsu_valid_o),
        .lsu_ready_i   (lsu_ready_i),
        .op_o          (op_o)
    );

    // 4 ns period
    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s expected 0x%08h got 0x%08h", name, exp, act));
        end
    endtask

    // Unit readies for the coming cycle, a pending stall overrides the policy
    task automatic apply_readies();
        logic [2:0] rdy;
        if (stall_left > 0) begin
            rdy        = 3'b000;
            stall_left = stall_left - 1;
        end else if (hold_mode == HOLD_LOW) begin
            rdy = 3'b000;
        end else if (hold_mode == HOLD_HIGH) begin
            rdy = 3'b111;
        end else begin
            rng_state = xorshift32(rng_state);
            rdy       = rng_state[2:0];
        end
        {alu_ready_i, br_ready_i, lsu_ready_i} = rdy;
    endtask

    task automatic next_cycle();
        @(negedge clk_i);
        apply_readies();
    endtask

    // Offer one table row and wait for its fetch handshake
    // pc encodes the row so the monitor can find the expected values
    task automatic push_row(input int row, input int pass);
        @(negedge clk_i);
        if (STIM[row].stall != 8'd0) begin
            stall_left = int'(STIM[row].stall);
        end
        apply_readies();
        fetch_valid_i = 1'b1;
        fetch_i.pc    = 32'(4 * (pass * NUM_ROWS + row));
        fetch_i.instr = STIM[row].instr;
        @(posedge clk_i);
        while (!fetch_ready_o) begin
            next_cycle();
            @(posedge clk_i);
        end
    endtask

    // Stop offering and let the units take everything queued
    task automatic drain_model();
        next_cycle();
        fetch_valid_i = 1'b0;
        while (model.size() != 0) begin
            next_cycle();
        end
        // Nothing may be left waiting in the queue once the model is empty
        check_val("unit_valids", 32'd0, 32'({alu_valid_o, br_valid_o, lsu_valid_o}));
    endtask

    // Monitor, handshakes sampled on the rising edge
    always @(posedge clk_i) begin
        exp_op_t    exp_op;
        logic [2:0] vld;
        logic [1:0] unit;
        int         row;
        if (rst_n_i) begin
            cycle_cnt = cycle_cnt + 1;
            vld       = {alu_valid_o, br_valid_o, lsu_valid_o};
            if (cycle_cnt > TIMEOUT_CYC) begin
                abort_run($sformatf("Timeout after %0d cycles with %0d operations still expected",
                                    cycle_cnt, model.size()));
            end else if ($countones(vld) > 1) begin
                abort_run("More than one execution unit valid in the same cycle");
            end else if (flush_i) begin
                // Queued work is gone, pushes and pops of this edge are dropped
                model.delete();
            end else begin
                if ((alu_valid_o && alu_ready_i) || (br_valid_o && br_ready_i) ||
                    (lsu_valid_o && lsu_ready_i)) begin
                    if (model.size() == 0) begin
                        abort_run("A unit accepted an operation that was never pushed");
                    end else begin
                        unit   = alu_valid_o ? U_ALU : (br_valid_o ? U_BR : U_LSU);
                        exp_op = model.pop_front();
                        check_val("unit_sel", 32'(exp_op.unit), 32'(unit));
                        check_val("op_o.pc", exp_op.pc, op_o.pc);
                        check_val("op_o.instr", exp_op.instr, op_o.instr);
                        check_val("op_o.except", 32'(exp_op.except), 32'(op_o.except));
                    end
                end
                // Push after pop, a same-edge push lands behind the popped head
                if (fetch_valid_i && fetch_ready_o) begin
                    row           = int'(fetch_i.pc >> 2) % NUM_ROWS;
                    exp_op.pc     = fetch_i.pc;
                    exp_op.instr  = fetch_i.instr;
                    exp_op.unit   = STIM[row].unit;
                    exp_op.except = STIM[row].except;
                    model.push_back(exp_op);
                end
            end
        end
    end

    initial begin
        rng_state     = 32'ha4d9ceae;
        hold_mode     = HOLD_RAND;
        stall_left    = 0;
        cycle_cnt     = 0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_i       = '0;
        alu_ready_i   = 1'b0;
        br_ready_i    = 1'b0;
        lsu_ready_i   = 1'b0;
        repeat (5) @(negedge clk_i);
        rst_n_i = 1'b1;
        // Idle state straight out of reset
        check_val("fetch_ready_o", 32'd1, 32'(fetch_ready_o));
        check_val("unit_valids", 32'd0, 32'({alu_valid_o, br_valid_o, lsu_valid_o}));

        // Whole table in program order under random back-pressure
        for (int r = 0; r < NUM_ROWS; r++) begin
            push_row(r, 0);
        end
        drain_model();

        // Units blocked, queue takes IQ_DEPTH entries and then refuses
        hold_mode = HOLD_LOW;
        for (int r = 0; r < IQ_DEPTH; r++) begin
            push_row(r, 1);
        end
        next_cycle();
        fetch_valid_i = 1'b1;
        fetch_i.pc    = 32'(4 * (NUM_ROWS + IQ_DEPTH));
        fetch_i.instr = STIM[IQ_DEPTH].instr;
        repeat (3) begin
            @(posedge clk_i);
            check_val("fetch_ready_o", 32'd0, 32'(fetch_ready_o));
            next_cycle();
        end
        // Head unit turns ready, push and pop share the next edge
        stall_left = 0;
        hold_mode  = HOLD_HIGH;
        apply_readies();
        @(posedge clk_i);
        check_val("fetch_ready_o", 32'd1, 32'(fetch_ready_o));
        hold_mode = HOLD_RAND;
        drain_model();

        // Flush with entries queued and a push offered in the same cycle
        hold_mode = HOLD_LOW;
        for (int r = 0; r < 3; r++) begin
            push_row(r, 2);
        end
        next_cycle();
        flush_i       = 1'b1;
        fetch_i.pc    = 32'(4 * (2 * NUM_ROWS + 3));
        fetch_i.instr = STIM[3].instr;
        next_cycle();
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        check_val("unit_valids", 32'd0, 32'({alu_valid_o, br_valid_o, lsu_valid_o}));
        // Work after the flush must be the first to leave
        hold_mode = HOLD_RAND;
        for (int r = 4; r < 7; r++) begin
            push_row(r, 3);
        end
        drain_model();

        if (model.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("Reference queue still holds operations at the end of the run");
        end
    end

endmodule

/* tests/issue_stage_assert.sv */
// Concurrent checks on issue queue handshakes and flush, bound into every issue_queue_fifo
`timescale 1ns/1ps

module issue_stage_assert
    import expipe_pkg::*;
(
    input logic      clk_i,
    input logic      rst_n_i,
    input logic      flush_i,
    input logic      push_i,
    input logic      pop_i,
    input logic      tail_busy_i,
    input logic      tail_is_head_i,
    input logic      issue_valid_i,
    input logic      issue_ready_i,
    input iq_entry_t issued_i
);

    // Stalled head stays put
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (issue_valid_i && !issue_ready_i && !flush_i) |=> (issue_valid_i && $stable(issued_i)))
        else $error("head entry changed while waiting for its unit");

    // Queue is empty right after a flush
    a_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !issue_valid_i)
        else $error("issue valid still high in the cycle after a flush");

    // An occupied slot only takes a push when it is the head leaving on the same edge
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (push_i && tail_busy_i) |-> (pop_i && tail_is_head_i))
        else $error("push accepted into an occupied issue queue slot");

endmodule

bind issue_queue_fifo issue_stage_assert i_issue_stage_assert (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .push_i         (tail_cnt_en_o),
    .pop_i          (head_cnt_en_o),
    .tail_busy_i    (valid_q[tail_idx_i]),
    .tail_is_head_i (head_idx_i == tail_idx_i),
    .issue_valid_i  (issue_valid_o),
    .issue_ready_i  (issue_ready_i),
    .issued_i       (issued_o)
);

/* source/issue_stage.sv */
// Issue stage top level: decoder, issue queue, head/tail counters and unit dispatcher
`timescale 1ns/1ps

module issue_stage
    import core_pkg::*;
    import expipe_pkg::*;
#(
    parameter int IQ_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    // Fetch side
    input  logic      fetch_valid_i,
    input  fetch_t    fetch_i,
    output logic      fetch_ready_o,
    // Execution units
    output logic      alu_valid_o,
    input  logic      alu_ready_i,
    output logic      br_valid_o,
    input  logic      br_ready_i,
    output logic      lsu_valid_o,
    input  logic      lsu_ready_i,
    output issue_op_t op_o
);

    localparam int IDX_W = $clog2(IQ_DEPTH);

    iq_entry_t        new_entry;
    iq_entry_t        issued;
    logic             issue_valid;
    logic             issue_ready;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] tail_idx;
    logic             head_cnt_en;
    logic             tail_cnt_en;
    logic             head_cnt_clr;
    logic             tail_cnt_clr;

    instr_decoder i_instr_decoder (
        .fetch_i (fetch_i),
        .entry_o (new_entry)
    );

    issue_queue_fifo #(
        .IQ_DEPTH (IQ_DEPTH)
    ) i_issue_queue_fifo (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_ready_o  (fetch_ready_o),
        .issue_ready_i  (issue_ready),
        .issue_valid_o  (issue_valid),
        .new_entry_i    (new_entry),
        .issued_o       (issued),
        .head_idx_i     (head_idx),
        .tail_idx_i     (tail_idx),
        .head_cnt_en_o  (head_cnt_en),
        .tail_cnt_en_o  (tail_cnt_en),
        .head_cnt_clr_o (head_cnt_clr),
        .tail_cnt_clr_o (tail_cnt_clr)
    );

    // Head pointer, advanced on every pop
    modn_counter #(
        .IQ_DEPTH (IQ_DEPTH)
    ) i_head_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (head_cnt_en),
        .clr_i   (head_cnt_clr),
        .count_o (head_idx)
    );

    // Tail pointer, advanced on every push
    modn_counter #(
        .IQ_DEPTH (IQ_DEPTH)
    ) i_tail_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (tail_cnt_en),
        .clr_i   (tail_cnt_clr),
        .count_o (tail_idx)
    );

    issue_dispatch i_issue_dispatch (
        .issue_valid_i (issue_valid),
        .issue_ready_o (issue_ready),
        .issued_i      (issued),
        .alu_valid_o   (alu_valid_o),
        .alu_ready_i   (alu_ready_i),
        .br_valid_o    (br_valid_o),
        .br_ready_i    (br_ready_i),
        .lsu_valid_o   (lsu_valid_o),
        .lsu_ready_i   (lsu_ready_i),
        .op_o          (op_o)
    );

endmodule

/* source/issue_dispatch.sv */
// Steers the issue queue head to the ALU, branch or load/store unit by operation class
`timescale 1ns/1ps

module issue_dispatch
    import core_pkg::*;
    import expipe_pkg::*;
(
    // Queue side
    input  logic      issue_valid_i,
    output logic      issue_ready_o,
    input  iq_entry_t issued_i,
    // Integer ALU
    output logic      alu_valid_o,
    input  logic      alu_ready_i,
    // Branch unit
    output logic      br_valid_o,
    input  logic      br_ready_i,
    // Load/store unit
    output logic      lsu_valid_o,
    input  logic      lsu_ready_i,
    // Payload shared by all units
    output issue_op_t op_o
);

    always_comb begin
        alu_valid_o   = 1'b0;
        br_valid_o    = 1'b0;
        lsu_valid_o   = 1'b0;
        issue_ready_o = 1'b0;

        // One-hot unit valid, ready taken from the selected unit only
        case (issued_i.op_class)
            OP_ALU: begin
                alu_valid_o   = issue_valid_i;
                issue_ready_o = alu_ready_i;
            end
            OP_BRANCH: begin
                br_valid_o    = issue_valid_i;
                issue_ready_o = br_ready_i;
            end
            OP_LSU: begin
                lsu_valid_o   = issue_valid_i;
                issue_ready_o = lsu_ready_i;
            end
            default: issue_ready_o = 1'b0;
        endcase
    end

    // Queue bookkeeping fields stay behind
    assign op_o.except = issued_i.except;
    assign op_o.pc     = issued_i.pc;
    assign op_o.instr  = issued_i.instr;

endmodule

/* source/issue_queue_fifo.sv */
// Circular issue queue with valid/ready handshakes; pointers come from external counters
`timescale 1ns/1ps

module issue_queue_fifo
    import expipe_pkg::*;
#(
    parameter int IQ_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    // Fetch side handshake
    input  logic                        fetch_valid_i,
    output logic                        fetch_ready_o,
    // Dispatch side handshake
    input  logic                        issue_ready_i,
    output logic                        issue_valid_o,
    // Entry in and head entry out
    input  iq_entry_t                   new_entry_i,
    output iq_entry_t                   issued_o,
    // Pointer counters
    input  logic [$clog2(IQ_DEPTH)-1:0] head_idx_i,
    input  logic [$clog2(IQ_DEPTH)-1:0] tail_idx_i,
    output logic                        head_cnt_en_o,
    output logic                        tail_cnt_en_o,
    output logic                        head_cnt_clr_o,
    output logic                        tail_cnt_clr_o
);

    // Slot occupancy, one bit per entry
    logic [IQ_DEPTH-1:0] valid_q;
    // Slot payload
    iq_entry_t           data_q [IQ_DEPTH];

    logic fifo_full;
    logic fifo_push;
    logic fifo_pop;

    // Full only when every slot holds an entry
    assign fifo_full = &valid_q;

    // Head slot occupied means something to issue
    assign issue_valid_o = valid_q[head_idx_i];

    // Room for a new entry, or the head leaves on this same edge
    assign fetch_ready_o = !fifo_full || (issue_valid_o && issue_ready_i);

    // Requests coinciding with a flush are discarded
    assign fifo_pop  = issue_valid_o && issue_ready_i && !flush_i;
    assign fifo_push = fetch_valid_i && fetch_ready_o && !flush_i;

    // Pointer control
    assign head_cnt_en_o  = fifo_pop;
    assign tail_cnt_en_o  = fifo_push;
    assign head_cnt_clr_o = flush_i;
    assign tail_cnt_clr_o = flush_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            // Dropping the valid bits is enough to empty the queue
            valid_q <= '0;
        end else begin
            if (fifo_pop) begin
                valid_q[head_idx_i] <= 1'b0;
            end
            // On a full queue head and tail coincide, so the push must win
            if (fifo_push) begin
                valid_q[tail_idx_i] <= 1'b1;
            end
        end
    end

    // Payload write port at the tail
    always_ff @(posedge clk_i) begin
        if (fifo_push) begin
            data_q[tail_idx_i] <= new_entry_i;
        end
    end

    // Head read port, valid taken from the occupancy vector
    always_comb begin
        issued_o       = data_q[head_idx_i];
        issued_o.valid = valid_q[head_idx_i];
    end

endmodule

/* source/instr_decoder.sv */
// Combinational decoder that turns a fetched instruction into an issue queue entry
`timescale 1ns/1ps

module instr_decoder
    import core_pkg::*;
    import expipe_pkg::*;
(
    input  fetch_t    fetch_i,
    output iq_entry_t entry_o
);

    // RV32I base opcodes, bits [6:2] of the instruction
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011
    } base_opc_e;

    base_opc_e opcode;
    logic      quad_ok;

    // Only 32-bit encodings are legal here, low bits must be 11
    assign quad_ok = (fetch_i.instr[1:0] == 2'b11);
    assign opcode  = base_opc_e'(fetch_i.instr[6:2]);

    always_comb begin
        entry_o.valid    = 1'b1;
        entry_o.pc       = fetch_i.pc;
        entry_o.instr    = fetch_i.instr;
        entry_o.op_class = OP_ALU;
        entry_o.except   = 1'b0;

        case (opcode)
            // Integer arithmetic and upper immediates
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: entry_o.op_class = OP_ALU;
            // Control transfers
            OPC_BRANCH, OPC_JAL, OPC_JALR:          entry_o.op_class = OP_BRANCH;
            // Memory access
            OPC_LOAD, OPC_STORE:                    entry_o.op_class = OP_LSU;
            default: begin
                // Unknown opcode, the ALU raises the exception
                entry_o.op_class = OP_ALU;
                entry_o.except   = 1'b1;
            end
        endcase

        // Compressed or reserved encodings are illegal whatever the opcode
        if (!quad_ok) begin
            entry_o.op_class = OP_ALU;
            entry_o.except   = 1'b1;
        end
    end

endmodule

/* source/modn_counter.sv */
// Wrapping modulo-IQ_DEPTH pointer counter, instantiated for the issue queue head and tail
`timescale 1ns/1ps

module modn_counter #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        en_i,
    input  logic                        clr_i,
    output logic [$clog2(IQ_DEPTH)-1:0] count_o
);

    localparam int IDX_W = $clog2(IQ_DEPTH);

    // Last index before wrapping back to zero
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(IQ_DEPTH - 1);

    logic [IDX_W-1:0] count_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clr_i) begin
            // Clear wins over a simultaneous enable
            count_q <= '0;
        end else if (en_i) begin
            if (count_q == LAST_IDX) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign count_o = count_q;

endmodule

/* source/expipe_pkg.sv */
// Execution-pipeline types used by the issue queue, the dispatcher and the top level
package expipe_pkg;

    import core_pkg::*;

    // One issue queue slot
    // Valid marks an occupied slot, except flags an illegal instruction
    typedef struct packed {
        logic      valid;
        op_class_e op_class;
        logic      except;
        pc_t       pc;
        instr_t    instr;
    } iq_entry_t;

    // Operation handed to an execution unit
    // Same payload for all three units, the unit valid says who owns it
    typedef struct packed {
        logic   except;
        pc_t    pc;
        instr_t instr;
    } issue_op_t;

endpackage

/* source/core_pkg.sv */
// Instruction-level types shared by the decoder, the dispatcher and the fetch interface
package core_pkg;

    // Raw 32-bit RISC-V instruction word
    typedef logic [31:0] instr_t;

    // Program counter, byte address
    typedef logic [31:0] pc_t;

    // Execution unit class an instruction is steered to
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_BRANCH = 2'd1,
        OP_LSU    = 2'd2
    } op_class_e;

    // Fetched instruction as delivered by the fetch unit
    // pc in the upper half, instruction word in the lower half
    typedef struct packed {
        pc_t    pc;
        instr_t instr;
    } fetch_t;

endpackage
